/* project.f */
+incdir+rtl
rtl/mdu_pkg.sv
rtl/mdu_multiplier.sv
rtl/mdu_divider.sv
rtl/multi_divide_unit.sv
rtl/hilo_regs.sv
rtl/mdu_top.sv
testbench/mdu_checker.sv
testbench/tb_mdu.sv

/* Bender.yml */
package:
  name: mdu

export_include_dirs:
  - rtl

sources:
  # design, package first
  - include_dirs:
      - rtl
    files:
      - rtl/mdu_pkg.sv
      - rtl/mdu_multiplier.sv
      - rtl/mdu_divider.sv
      - rtl/multi_divide_unit.sv
      - rtl/hilo_regs.sv
      - rtl/mdu_top.sv

  # testbench, top is tb_mdu
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/mdu_checker.sv
      - testbench/tb_mdu.sv

/* testbench/tb_mdu.sv */
`timescale 1ns/1ns
`include "mdu_consts.svh"

module tb_mdu;
    localparam int W       = `MDU_WORD_W;
    localparam int N_MUL   = 24;                     // back to back multiplies
    localparam int N_ACC   = 8;                      // accumulate ops
    localparam int N_DIV   = 12;                     // random divides
    localparam int MUL_CYC = `MDU_MUL_STAGES + 4;
    localparam int DIV_CYC = `MDU_DIV_STEPS + 4;
    // sum over the tests in order, then a margin
    localparam int LIMIT_CYC = 8 + (N_MUL + 1) * MUL_CYC + (N_ACC + 4) * MUL_CYC
                             + (N_DIV + 6) * DIV_CYC + (9 * MUL_CYC + 2 * DIV_CYC)
                             + (6 * MUL_CYC + 3 * DIV_CYC) + 100;

    logic             clk_i;
    logic             arst_n_i;
    logic             req_i;
    logic             cancel_i;
    mdu_pkg::mdu_op_e op_i;
    logic [W-1:0]     opa_i;
    logic [W-1:0]     opb_i;
    logic             accept_o;
    logic             done_o;
    logic [W-1:0]     hi_o;
    logic [W-1:0]     lo_o;
    int               chk_errors;
    int               chk_pending;
    int               chk_done;
    int               tb_errors = 0;
    int               cycles    = 0;
    logic [31:0]      lfsr;

    mdu_top uut (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .req_i(req_i), .op_i(op_i), .opa_i(opa_i),
        .opb_i(opb_i), .cancel_i(cancel_i), .accept_o(accept_o), .done_o(done_o),
        .hi_o(hi_o), .lo_o(lo_o)
    );

    mdu_checker chk (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .req_i(req_i), .op_i(op_i), .opa_i(opa_i),
        .opb_i(opb_i), .cancel_i(cancel_i), .accept_i(accept_o), .done_i(done_o),
        .hi_i(hi_o), .lo_i(lo_o), .errors_o(chk_errors), .pending_o(chk_pending),
        .done_cnt_o(chk_done)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // hang guard
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT_CYC) begin
            $display("timeout, run did not end within %0d cycles", LIMIT_CYC);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // expected {hi, lo} after one operation
    // ------------------------------------------------------------------------
    function automatic logic [2*W-1:0] mdu_ref(input mdu_pkg::mdu_op_e op,
                                               input logic [W-1:0] a, input logic [W-1:0] b,
                                               input logic [2*W-1:0] hilo);
        logic [2*W-1:0] ps;
        logic [2*W-1:0] pu;
        logic [W-1:0]   ma;
        logic [W-1:0]   mb;
        logic [W-1:0]   qm;
        logic [W-1:0]   rm;
        logic           sgn;
        ps  = {{W{a[W-1]}}, a} * {{W{b[W-1]}}, b};   // low 2W bits of signed product
        pu  = {{W{1'b0}}, a} * {{W{1'b0}}, b};
        sgn = (op == mdu_pkg::op_div);
        ma  = (sgn && a[W-1]) ? -a : a;              // magnitudes
        mb  = (sgn && b[W-1]) ? -b : b;
        if (mb == '0) begin
            qm = '1;                                 // zero divisor rule
            rm = ma;
        end else begin
            qm = ma / mb;
            rm = ma % mb;
        end
        if (sgn && (a[W-1] ^ b[W-1])) qm = -qm;
        if (sgn && a[W-1]) rm = -rm;                 // remainder follows dividend
        case (op)
            mdu_pkg::op_mult:  return ps;
            mdu_pkg::op_multu: return pu;
            mdu_pkg::op_madd:  return hilo + ps;
            mdu_pkg::op_maddu: return hilo + pu;
            mdu_pkg::op_msub:  return hilo - ps;
            mdu_pkg::op_msubu: return hilo - pu;
            mdu_pkg::op_div,
            mdu_pkg::op_divu:  return {rm, qm};
            mdu_pkg::op_mthi:  return {a, hilo[W-1:0]};
            mdu_pkg::op_mtlo:  return {hilo[2*W-1:W], a};
            default:           return hilo;
        endcase
    endfunction

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [W-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[W-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic int total_errors();
        return tb_errors + chk_errors;
    endfunction

    // ------------------------------------------------------------------------
    // drive helpers, entered and left 1 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic issue(input mdu_pkg::mdu_op_e op, input logic [W-1:0] a,
                         input logic [W-1:0] b);
        req_i = 1'b1;
        op_i  = op;
        opa_i = a;
        opb_i = b;
        @(negedge clk_i);
        while (!accept_o) @(negedge clk_i);          // held until taken
        @(posedge clk_i);
        #1;
        req_i = 1'b0;
        op_i  = mdu_pkg::op_nop;
    endtask

    task automatic pulse_cancel();
        cancel_i = 1'b1;
        @(posedge clk_i);
        #1;
        cancel_i = 1'b0;
    endtask

    task automatic wait_idle();
        while (chk_pending != 0) @(posedge clk_i);
        repeat (2) @(posedge clk_i);                 // let the last write be compared
        #1;
    endtask

    task automatic report_test(input string name, input int e0);
        $display("test %-10s done, %0d errors", name, total_errors() - e0);
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic test_reset();
        int e0;
        e0 = total_errors();
        if (hi_o !== '0) begin
            $display("MISMATCH t=%0t hi_o expected %h got %h", $time, 32'h0, hi_o);
            tb_errors++;
        end
        if (lo_o !== '0) begin
            $display("MISMATCH t=%0t lo_o expected %h got %h", $time, 32'h0, lo_o);
            tb_errors++;
        end
        if (done_o !== 1'b0 || accept_o !== 1'b1) begin
            $display("t=%0t after reset done_o must be low and accept_o high", $time);
            tb_errors++;
        end
        report_test("reset", e0);
    endtask

    task automatic test_mul();
        logic [W-1:0]     s;
        logic [W-1:0]     a;
        logic [W-1:0]     b;
        mdu_pkg::mdu_op_e op;
        int               e0;
        e0 = total_errors();
        for (int i = 0; i < N_MUL; i++) begin
            take_bits(1, s);
            take_bits(W, a);
            take_bits(W, b);
            if (s[0]) op = mdu_pkg::op_mult;
            else      op = mdu_pkg::op_multu;
            issue(op, a, b);
        end
        wait_idle();
        report_test("multiply", e0);
    endtask

    task automatic test_acc();
        logic [W-1:0]     a;
        logic [W-1:0]     b;
        mdu_pkg::mdu_op_e op;
        int               e0;
        e0 = total_errors();
        for (int i = 0; i < N_ACC; i++) begin
            if (i % 4 == 0) begin                    // fresh hi:lo each round
                take_bits(W, a);
                issue(mdu_pkg::op_mthi, a, 32'h0);
                take_bits(W, a);
                issue(mdu_pkg::op_mtlo, a, 32'h0);
            end
            case (i % 4)
                0:       op = mdu_pkg::op_madd;
                1:       op = mdu_pkg::op_maddu;
                2:       op = mdu_pkg::op_msub;
                default: op = mdu_pkg::op_msubu;
            endcase
            take_bits(W, a);
            take_bits(W, b);
            issue(op, a, b);
        end
        wait_idle();
        report_test("accumulate", e0);
    endtask

    task automatic test_div();
        logic [W-1:0]     a;
        logic [W-1:0]     b;
        logic [W-1:0]     s;
        mdu_pkg::mdu_op_e op;
        int               n;
        int               e0;
        e0 = total_errors();
        take_bits(W, a);
        issue(mdu_pkg::op_divu, a, 32'h0);           // zero divisors
        issue(mdu_pkg::op_div, 32'hffff_fff3, 32'h0);
        issue(mdu_pkg::op_div, 32'h8000_0000, 32'hffff_ffff);
        issue(mdu_pkg::op_div, 32'h8000_0000, 32'h7);
        issue(mdu_pkg::op_divu, 32'h8000_0000, 32'h3);
        for (int i = 0; i < N_DIV; i++) begin
            take_bits(1, s);
            take_bits(5, b);
            n = b[4:0] + 1;                          // vary divisor size
            take_bits(W, a);
            take_bits(n, b);
            if (s[0]) op = mdu_pkg::op_div;
            else      op = mdu_pkg::op_divu;
            issue(op, a, b);
        end
        wait_idle();
        report_test("divide", e0);
    endtask

    task automatic test_interlock();
        logic [W-1:0] a;
        logic [W-1:0] b;
        int           e0;
        e0 = total_errors();
        repeat (3) begin
            take_bits(W, a);
            take_bits(W, b);
            issue(mdu_pkg::op_mult, a, b);
        end
        issue(mdu_pkg::op_div, a, b);                // must wait for the burst
        issue(mdu_pkg::op_multu, b, a);              // waits for the divider
        issue(mdu_pkg::op_mult, a, a);
        issue(mdu_pkg::op_madd, b, b);
        issue(mdu_pkg::op_multu, a, b);
        issue(mdu_pkg::op_mtlo, b, 32'h0);
        wait_idle();
        report_test("interlock", e0);
    endtask

    task automatic test_cancel();
        logic [W-1:0] a;
        logic [W-1:0] b;
        int           e0;
        e0 = total_errors();
        take_bits(W, a);
        take_bits(W, b);
        issue(mdu_pkg::op_div, a, b);
        repeat (8) @(posedge clk_i);
        #1;
        pulse_cancel();                              // mid division
        repeat (DIV_CYC) @(posedge clk_i);
        #1;
        repeat (3) begin
            take_bits(W, a);
            take_bits(W, b);
            issue(mdu_pkg::op_multu, a, b);
        end
        pulse_cancel();                              // burst still in the pipe
        issue(mdu_pkg::op_mthi, a, 32'h0);
        pulse_cancel();                              // move about to write
        repeat (MUL_CYC) @(posedge clk_i);
        #1;
        issue(mdu_pkg::op_mult, b, a);               // unit still usable
        wait_idle();
        report_test("cancel", e0);
    endtask

    initial begin
        arst_n_i = 1'b0;
        req_i    = 1'b0;
        cancel_i = 1'b0;
        op_i     = mdu_pkg::op_nop;
        opa_i    = '0;
        opb_i    = '0;
        lfsr     = 32'h9ee3_d081;
        repeat (3) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        test_reset();
        test_mul();
        test_acc();
        test_div();
        test_interlock();
        test_cancel();
        $display("6 tests, %0d results written, %0d errors", chk_done, total_errors());
        if (total_errors() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* testbench/mdu_checker.sv */
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_checker (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   req_i,
    input  mdu_pkg::mdu_op_e       op_i,
    input  logic [`MDU_WORD_W-1:0] opa_i,
    input  logic [`MDU_WORD_W-1:0] opb_i,
    input  logic                   cancel_i,
    input  logic                   accept_i,
    input  logic                   done_i,
    input  logic [`MDU_WORD_W-1:0] hi_i,
    input  logic [`MDU_WORD_W-1:0] lo_i,
    output int                     errors_o,
    output int                     pending_o,   // accepted, not yet written
    output int                     done_cnt_o
);
    localparam int W = `MDU_WORD_W;

    typedef struct packed {
        mdu_pkg::mdu_op_e op;
        logic [W-1:0]     a;
        logic [W-1:0]     b;
    } op_rec_t;

    op_rec_t        pend_q [$];      // in acceptance order
    op_rec_t        rec;
    logic [2*W-1:0] model;           // expected {hi, lo}
    int             errors   = 0;
    int             done_cnt = 0;
    int             pend_n   = 0;
    int             n_mul;
    int             n_div;

    assign errors_o   = errors;
    assign pending_o  = pend_n;
    assign done_cnt_o = done_cnt;

    function automatic logic is_div(input mdu_pkg::mdu_op_e op);
        return op == mdu_pkg::op_div || op == mdu_pkg::op_divu;
    endfunction

    // accumulates and moves need an empty unit
    function automatic logic needs_idle(input mdu_pkg::mdu_op_e op);
        return op == mdu_pkg::op_madd || op == mdu_pkg::op_maddu ||
               op == mdu_pkg::op_msub || op == mdu_pkg::op_msubu ||
               op == mdu_pkg::op_mthi || op == mdu_pkg::op_mtlo;
    endfunction

    task automatic report_mismatch(input string sig, input logic [W-1:0] exp,
                                   input logic [W-1:0] got);
        $display("MISMATCH t=%0t %s expected %h got %h", $time, sig, exp, got);
        errors++;
    endtask

    // ------------------------------------------------------------------------
    // sampled mid cycle, inputs and outputs are stable here
    // ------------------------------------------------------------------------
    always @(negedge clk_i) begin
        if (!arst_n_i) begin
            model = '0;
            pend_q.delete();
        end else begin
            // hi/lo hold the model every cycle, writes land one cycle after done
            if (hi_i !== model[2*W-1:W]) report_mismatch("hi_o", model[2*W-1:W], hi_i);
            if (lo_i !== model[W-1:0])   report_mismatch("lo_o", model[W-1:0], lo_i);
            if (cancel_i) begin
                if (done_i) begin
                    $display("t=%0t done_o pulsed while cancel_i was high", $time);
                    errors++;
                end
                if (accept_i) begin
                    $display("t=%0t accept_o was high while cancel_i was high", $time);
                    errors++;
                end
                pend_q.delete();                     // everything in flight is gone
            end else begin
                if (req_i && accept_i) begin
                    n_mul = 0;
                    n_div = 0;
                    for (int i = 0; i < pend_q.size(); i++) begin
                        rec = pend_q[i];
                        if (is_div(rec.op)) n_div++;
                        else if (rec.op != mdu_pkg::op_mthi && rec.op != mdu_pkg::op_mtlo)
                            n_mul++;
                    end
                    if ((is_div(op_i) && (n_mul + n_div) != 0) ||
                        (needs_idle(op_i) && pend_q.size() != 0) ||
                        (!is_div(op_i) && !needs_idle(op_i) && n_div != 0)) begin
                        $display("t=%0t interlock broken, op %0d accepted with %0d in flight",
                                 $time, op_i, pend_q.size());
                        errors++;
                    end
                end
                if (done_i) begin
                    done_cnt++;
                    if (pend_q.size() == 0) begin
                        $display("t=%0t done_o pulsed with no operation outstanding", $time);
                        errors++;
                    end else begin
                        rec   = pend_q.pop_front();
                        model = tb_mdu.mdu_ref(rec.op, rec.a, rec.b, model);
                    end
                end
                if (req_i && accept_i && op_i != mdu_pkg::op_nop) begin
                    rec.op = op_i;
                    rec.a  = opa_i;
                    rec.b  = opb_i;
                    pend_q.push_back(rec);
                end
            end
        end
        pend_n = pend_q.size();
    end

endmodule

/* rtl/mdu_top.sv */
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_top (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   req_i,      // held until accept_o
    input  mdu_pkg::mdu_op_e       op_i,
    input  logic [`MDU_WORD_W-1:0] opa_i,      // dividend / move source
    input  logic [`MDU_WORD_W-1:0] opb_i,      // divisor
    input  logic                   cancel_i,   // flush all in flight
    output logic                   accept_o,
    output logic                   done_o,     // hi/lo written this cycle
    output logic [`MDU_WORD_W-1:0] hi_o,
    output logic [`MDU_WORD_W-1:0] lo_o
);
    mdu_pkg::hilo_we_t            hilo_we;
    logic [2*`MDU_WORD_W-1:0]     hilo_wdata;

    // ------------------------------------------------------------------------
    // arithmetic, reads hi:lo back for accumulate
    // ------------------------------------------------------------------------
    multi_divide_unit u_mdu (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_i        (req_i),
        .op_i         (op_i),
        .opa_i        (opa_i),
        .opb_i        (opb_i),
        .cancel_i     (cancel_i),
        .hilo_i       ({hi_o, lo_o}),
        .accept_o     (accept_o),
        .done_o       (done_o),
        .hilo_we_o    (hilo_we),
        .hilo_wdata_o (hilo_wdata)
    );

    // result registers
    hilo_regs u_hilo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (hilo_we),
        .wdata_i  (hilo_wdata),
        .hi_o     (hi_o),
        .lo_o     (lo_o)
    );

endmodule

/* rtl/hilo_regs.sv */
`timescale 1ns/1ns
`include "mdu_consts.svh"

module hilo_regs (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  mdu_pkg::hilo_we_t        we_i,
    input  logic [2*`MDU_WORD_W-1:0] wdata_i,   // {hi, lo}
    output logic [`MDU_WORD_W-1:0]   hi_o,
    output logic [`MDU_WORD_W-1:0]   lo_o
);
    localparam int W = `MDU_WORD_W;

    // ------------------------------------------------------------------------
    // architectural hi/lo, both start at zero
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_o <= '0;
        end else if (we_i.hi) begin
            hi_o <= wdata_i[2*W-1:W];   // remainder or upper product
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lo_o <= '0;
        end else if (we_i.lo) begin
            lo_o <= wdata_i[W-1:0];     // quotient or lower product
        end
    end

endmodule

/* rtl/multi_divide_unit.sv */
`timescale 1ns/1ns
`include "mdu_consts.svh"

module multi_divide_unit (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     req_i,
    input  mdu_pkg::mdu_op_e         op_i,
    input  logic [`MDU_WORD_W-1:0]   opa_i,
    input  logic [`MDU_WORD_W-1:0]   opb_i,
    input  logic                     cancel_i,
    input  logic [2*`MDU_WORD_W-1:0] hilo_i,
    output logic                     accept_o,
    output logic                     done_o,
    output mdu_pkg::hilo_we_t        hilo_we_o,
    output logic [2*`MDU_WORD_W-1:0] hilo_wdata_o
);
    localparam int W = `MDU_WORD_W;

    logic is_mul, is_acc, is_sub, is_div, is_mv, is_signed;
    logic take;                        // request accepted this cycle
    logic mul_valid, mul_res_valid, mul_busy;
    logic [2*W-1:0] mul_res;
    logic div_start, div_busy, div_res_valid;
    logic [W-1:0] quotient, remainder;
    logic mv_q;                        // move waiting to write
    logic mv_hi_q;                     // mthi rather than mtlo
    logic [W-1:0] mv_word_q;
    logic mv_valid;

    // ------------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------------
    assign is_acc = op_i inside {mdu_pkg::op_madd, mdu_pkg::op_maddu,
                                 mdu_pkg::op_msub, mdu_pkg::op_msubu};
    assign is_sub = op_i inside {mdu_pkg::op_msub, mdu_pkg::op_msubu};
    assign is_mul = is_acc || (op_i inside {mdu_pkg::op_mult, mdu_pkg::op_multu});
    assign is_div = op_i inside {mdu_pkg::op_div, mdu_pkg::op_divu};
    assign is_mv  = op_i inside {mdu_pkg::op_mthi, mdu_pkg::op_mtlo};
    assign is_signed = op_i inside {mdu_pkg::op_mult, mdu_pkg::op_madd,
                                    mdu_pkg::op_msub, mdu_pkg::op_div};

    // interlock, plain multiplies may overlap each other only
    assign accept_o = !cancel_i && !div_busy && !(is_div && mul_busy) &&
                      !((is_acc || is_mv) && (mul_busy || mv_q));
    assign take      = req_i && accept_o;
    assign mul_valid = take && is_mul;
    assign div_start = take && is_div;

    mdu_multiplier u_mul (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .valid_i(mul_valid), .signed_i(is_signed),
        .accum_i(is_acc), .subtract_i(is_sub), .cancel_i(cancel_i), .opa_i(opa_i),
        .opb_i(opb_i), .hilo_i(hilo_i), .valid_o(mul_res_valid), .busy_o(mul_busy),
        .res_o(mul_res)
    );

    mdu_divider u_div (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .start_i(div_start), .signed_i(is_signed),
        .cancel_i(cancel_i), .dividend_i(opa_i), .divisor_i(opb_i), .busy_o(div_busy),
        .valid_o(div_res_valid), .quotient_o(quotient), .remainder_o(remainder)
    );

    // moves land one cycle after acceptance
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mv_q <= 1'b0;
        end else begin
            mv_q <= take && is_mv;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take && is_mv) begin
            mv_hi_q   <= (op_i == mdu_pkg::op_mthi);
            mv_word_q <= opa_i;
        end
    end

    assign mv_valid = mv_q && !cancel_i;

    // ------------------------------------------------------------------------
    // hi/lo write select, at most one source per cycle
    // ------------------------------------------------------------------------
    always_comb begin
        hilo_we_o    = '0;
        hilo_wdata_o = {mv_word_q, mv_word_q};   // move word on both halves
        if (div_res_valid) begin
            hilo_we_o    = '1;
            hilo_wdata_o = {remainder, quotient};
        end else if (mul_res_valid) begin
            hilo_we_o    = '1;
            hilo_wdata_o = mul_res;
        end else if (mv_valid) begin
            hilo_we_o.hi = mv_hi_q;
            hilo_we_o.lo = !mv_hi_q;
        end
    end

    assign done_o = div_res_valid || mul_res_valid || mv_valid;

endmodule

/* rtl/mdu_divider.sv */
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_divider (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   start_i,      // operands accepted this cycle
    input  logic                   signed_i,
    input  logic                   cancel_i,
    input  logic [`MDU_WORD_W-1:0] dividend_i,
    input  logic [`MDU_WORD_W-1:0] divisor_i,
    output logic                   busy_o,
    output logic                   valid_o,
    output logic [`MDU_WORD_W-1:0] quotient_o,
    output logic [`MDU_WORD_W-1:0] remainder_o
);
    localparam int W  = `MDU_WORD_W;
    localparam int CW = `MDU_DIV_CNT_W;

    logic          run_q;       // iterating
    logic          fix_q;       // sign fix cycle
    logic          valid_q;     // result cycle
    logic [CW-1:0] cnt_q;       // steps left minus one
    logic [W-1:0]  dvd_abs;
    logic [W-1:0]  dvs_abs;
    logic [W-1:0]  rem_q;       // partial remainder
    logic [W-1:0]  quo_q;       // dividend shifts out, quotient shifts in
    logic [W-1:0]  dvs_q;
    logic          neg_q_q;     // negate quotient at the end
    logic          neg_r_q;     // remainder follows the dividend sign
    logic [W:0]    rem_shift;
    logic [W:0]    trial;

    // ------------------------------------------------------------------------
    // control, counter runs W steps then one fix cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_q   <= 1'b0;
            fix_q   <= 1'b0;
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else if (cancel_i) begin
            run_q   <= 1'b0;                       // drop the division
            fix_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= fix_q;
            fix_q   <= run_q && (cnt_q == '0);
            if (start_i) begin
                run_q <= 1'b1;
                cnt_q <= CW'(`MDU_DIV_STEPS - 1);
            end else if (run_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == '0) begin
                    run_q <= 1'b0;                 // last step done
                end
            end
        end
    end

    // magnitudes taken in the accept cycle
    assign dvd_abs = (signed_i && dividend_i[W-1]) ? -dividend_i : dividend_i;
    assign dvs_abs = (signed_i && divisor_i[W-1]) ? -divisor_i : divisor_i;

    // restoring step, trial subtract on one extra bit
    assign rem_shift = {rem_q, quo_q[W-1]};
    assign trial     = rem_shift - {1'b0, dvs_q};

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rem_q   <= '0;
            quo_q   <= dvd_abs;
            dvs_q   <= dvs_abs;
            neg_q_q <= signed_i & (dividend_i[W-1] ^ divisor_i[W-1]);
            neg_r_q <= signed_i & dividend_i[W-1];
        end else if (run_q) begin
            if (!trial[W]) begin
                rem_q <= trial[W-1:0];             // fits, keep the difference
                quo_q <= {quo_q[W-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[W-1:0];         // restore
                quo_q <= {quo_q[W-2:0], 1'b0};
            end
        end
        if (fix_q) begin
            quotient_o  <= neg_q_q ? -quo_q : quo_q;
            remainder_o <= neg_r_q ? -rem_q : rem_q;
        end
    end

    // zero divisor needs no special case, every trial fits
    assign busy_o  = run_q | fix_q | valid_q;
    assign valid_o = valid_q & ~cancel_i;

endmodule

/* rtl/mdu_multiplier.sv */
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_multiplier (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     valid_i,     // operands accepted this cycle
    input  logic                     signed_i,
    input  logic                     accum_i,     // madd / msub family
    input  logic                     subtract_i,  // msub when set with accum_i
    input  logic                     cancel_i,
    input  logic [`MDU_WORD_W-1:0]   opa_i,
    input  logic [`MDU_WORD_W-1:0]   opb_i,
    input  logic [2*`MDU_WORD_W-1:0] hilo_i,      // current hi:lo for accumulate
    output logic                     valid_o,
    output logic                     busy_o,
    output logic [2*`MDU_WORD_W-1:0] res_o
);
    localparam int W = `MDU_WORD_W;
    localparam int N = `MDU_MUL_STAGES;

    logic signed [W:0]     opa_ext;    // sign or zero extended by one bit
    logic signed [W:0]     opb_ext;
    logic signed [2*W+1:0] prod_full;
    logic [N-1:0]          vld_q;      // one valid per stage
    logic [N-1:0]          acc_q;
    logic [N-1:0]          sub_q;
    logic [2*W-1:0]        prod_q [N];
    logic [2*W-1:0]        prod_last;

    // extend so one signed multiplier covers mult and multu
    assign opa_ext   = {signed_i & opa_i[W-1], opa_i};
    assign opb_ext   = {signed_i & opb_i[W-1], opb_i};
    assign prod_full = opa_ext * opb_ext;

    // ------------------------------------------------------------------------
    // stage valid bits
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= '0;
        end else if (cancel_i) begin
            vld_q <= '0;                          // flush everything in flight
        end else begin
            vld_q <= {vld_q[N-2:0], valid_i};
        end
    end

    // product formed in stage 0, then only carried
    always_ff @(posedge clk_i) begin
        prod_q[0] <= prod_full[2*W-1:0];
        acc_q[0]  <= accum_i;
        sub_q[0]  <= subtract_i;
        for (int i = 1; i < N; i++) begin
            prod_q[i] <= prod_q[i-1];
            acc_q[i]  <= acc_q[i-1];
            sub_q[i]  <= sub_q[i-1];
        end
    end

    // ------------------------------------------------------------------------
    // last stage, optional accumulate onto hi:lo
    // ------------------------------------------------------------------------
    assign prod_last = prod_q[N-1];

    always_comb begin
        if (acc_q[N-1] && sub_q[N-1]) begin
            res_o = hilo_i - prod_last;             // msub
        end else if (acc_q[N-1]) begin
            res_o = hilo_i + prod_last;             // madd
        end else begin
            res_o = prod_last;                      // plain product
        end
    end

    assign valid_o = vld_q[N-1] & ~cancel_i;  // a cancelled result never writes
    assign busy_o  = |vld_q;

endmodule

/* rtl/mdu_pkg.sv */
package mdu_pkg;

    // ------------------------------------------------------------------------
    // operation codes from the core decoder
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        op_mult  = 4'd0,   // signed hi:lo = a * b
        op_multu = 4'd1,   // unsigned product
        op_madd  = 4'd2,   // hi:lo += a * b, signed
        op_maddu = 4'd3,
        op_msub  = 4'd4,   // hi:lo -= a * b, signed
        op_msubu = 4'd5,
        op_div   = 4'd6,   // lo = quotient, hi = remainder
        op_divu  = 4'd7,
        op_mthi  = 4'd8,   // hi = a
        op_mtlo  = 4'd9,   // lo = a
        op_nop   = 4'd15   // nothing to do
    } mdu_op_e;

    // ------------------------------------------------------------------------
    // per-half write enable for the hi/lo pair
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic hi;   // upper word / remainder
        logic lo;   // lower word / quotient
    } hilo_we_t;

endpackage

/* rtl/mdu_consts.svh */
`ifndef MDU_CONSTS_SVH
`define MDU_CONSTS_SVH

// ----------------------------------------------------------------------------
// datapath sizing
// ----------------------------------------------------------------------------

// one gpr word, hi and lo are each this wide
`define MDU_WORD_W      32

// multiplier pipeline depth, 2 to 4 all close timing
`define MDU_MUL_STAGES  3

// ----------------------------------------------------------------------------
// divider sizing
// ----------------------------------------------------------------------------

// one quotient bit per iteration
`define MDU_DIV_STEPS   `MDU_WORD_W
// step counter width
`define MDU_DIV_CNT_W   $clog2(`MDU_DIV_STEPS)

`endif
